// ==== logic/cache_pkg.sv ====
package cache_pkg;

  // Cache geometry
  localparam int num_ways    = 4;
  localparam int offset_w    = 6;
  localparam int index_w     = 5;
  localparam int tag_w       = 21;
  localparam int word_sel_w  = 4;
  localparam int data_addr_w = index_w + word_sel_w;
  localparam int num_sets    = 1 << index_w;
  localparam int data_depth  = 1 << data_addr_w;

  // Top nibble of the uncached IO window
  localparam logic [3:0] io_region = 4'hF;

  typedef logic [31:0]            addr_t;
  typedef logic [31:0]            word_t;
  typedef logic [3:0]             be_t;
  typedef logic [1:0]             way_t;
  typedef logic [index_w-1:0]     index_t;
  typedef logic [tag_w-1:0]       tag_t;
  typedef logic [data_addr_w-1:0] data_addr_t;

  typedef enum logic [1:0] {
    cmd_nop    = 2'd0,
    cmd_refill = 2'd1,
    cmd_io     = 2'd2
  } rw_cmd_e;

  typedef enum logic {
    st_idle,
    st_wait
  } rw_state_e;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    be_t   be;
    logic  read;
    logic  write;
  } cpu_req_t;

  typedef struct packed {
    logic hit;
    way_t hit_way;
    logic has_free;
    way_t free_way;
  } lookup_t;

  // Driven by the external refill agent
  typedef struct packed {
    logic  tag_we;
    logic  data_we;
    way_t  way;
    addr_t addr;
    tag_t  tag;
    word_t wdata;
    be_t   be;
  } refill_wr_t;

  function automatic index_t to_index(input addr_t a);
    return a[offset_w +: index_w];
  endfunction

  function automatic tag_t to_tag(input addr_t a);
    return a[offset_w + index_w +: tag_w];
  endfunction

  // Set index followed by word within the line
  function automatic data_addr_t to_data_addr(input addr_t a);
    return {to_index(a), a[offset_w-1 -: word_sel_w]};
  endfunction

endpackage

// ==== logic/cache_tag_store.sv ====
`timescale 1ns/100ps

module cache_tag_store import cache_pkg::*; (
  input  logic       clk,
  input  logic       rest,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  input  addr_t      cmp_addr,
  input  refill_wr_t refill_wr,
  output lookup_t    lookup
);

  tag_t                               tag_mem [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0]  valid;
  tag_t                               rd_tag [num_ways];
  logic [num_ways-1:0]                rd_valid;
  logic [num_ways-1:0]                match;
  tag_t                               cmp_tag;

  // Tag array, written only by the refill agent
  always_ff @(posedge clk) begin
    if (refill_wr.tag_we) begin
      tag_mem[refill_wr.way][to_index(refill_wr.addr)] <= refill_wr.tag;
    end
    if (rd_en) begin
      for (int w = 0; w < num_ways; w++) begin
        rd_tag[w] <= tag_mem[w][to_index(rd_addr)];
      end
    end
  end

  // Valid bits come out of reset cleared
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      valid    <= '0;
      rd_valid <= '0;
    end else begin
      if (refill_wr.tag_we) begin
        valid[refill_wr.way][to_index(refill_wr.addr)] <= 1'b1;
      end
      if (rd_en) begin
        for (int w = 0; w < num_ways; w++) begin
          rd_valid[w] <= valid[w][to_index(rd_addr)];
        end
      end
    end
  end

  assign cmp_tag = to_tag(cmp_addr);

  // Walk downwards so the lowest matching or free way wins
  always_comb begin
    lookup = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      match[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
      if (match[w]) begin
        lookup.hit     = 1'b1;
        lookup.hit_way = way_t'(w);
      end
      if (!rd_valid[w]) begin
        lookup.has_free = 1'b1;
        lookup.free_way = way_t'(w);
      end
    end
  end

endmodule

// ==== logic/cache_data_store.sv ====
`timescale 1ns/100ps

module cache_data_store import cache_pkg::*; (
  input  logic       clk,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  input  way_t       hit_way,
  input  logic       hit_wr_en,
  input  addr_t      wr_addr,
  input  be_t        hit_wr_be,
  input  word_t      hit_wr_data,
  input  refill_wr_t refill_wr,
  output word_t      rd_word
);

  word_t      mem [num_ways][data_depth];
  word_t      rd_q [num_ways];
  logic       wr_en;
  way_t       wr_way;
  data_addr_t wr_idx;
  be_t        wr_be;
  word_t      wr_data;

  // Hit writes only happen in idle, refill writes only while waiting
  always_comb begin
    if (hit_wr_en) begin
      wr_en   = 1'b1;
      wr_way  = hit_way;
      wr_idx  = to_data_addr(wr_addr);
      wr_be   = hit_wr_be;
      wr_data = hit_wr_data;
    end else begin
      wr_en   = refill_wr.data_we;
      wr_way  = refill_wr.way;
      wr_idx  = to_data_addr(refill_wr.addr);
      wr_be   = refill_wr.be;
      wr_data = refill_wr.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_be[b]) begin
          mem[wr_way][wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
    // All ways read at accept, way picked once the tags are known
    if (rd_en) begin
      for (int w = 0; w < num_ways; w++) begin
        rd_q[w] <= mem[w][to_data_addr(rd_addr)];
      end
    end
  end

  assign rd_word = rd_q[hit_way];

endmodule

// ==== logic/cache_byte_valid.sv ====
`timescale 1ns/100ps

module cache_byte_valid import cache_pkg::*; (
  input  logic       clk,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  input  way_t       hit_way,
  input  logic       hit_wr_en,
  input  addr_t      wr_addr,
  input  be_t        hit_readable,
  input  refill_wr_t refill_wr,
  output be_t        rd_readable
);

  be_t        mem [num_ways][data_depth];
  be_t        rd_q [num_ways];
  logic       wr_en;
  way_t       wr_way;
  data_addr_t wr_idx;
  be_t        wr_bits;

  // A refill write with be zero marks the word unreadable
  always_comb begin
    if (hit_wr_en) begin
      wr_en   = 1'b1;
      wr_way  = hit_way;
      wr_idx  = to_data_addr(wr_addr);
      wr_bits = hit_readable;
    end else begin
      wr_en   = refill_wr.data_we;
      wr_way  = refill_wr.way;
      wr_idx  = to_data_addr(refill_wr.addr);
      wr_bits = refill_wr.be;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_way][wr_idx] <= wr_bits;
    end
    if (rd_en) begin
      for (int w = 0; w < num_ways; w++) begin
        rd_q[w] <= mem[w][to_data_addr(rd_addr)];
      end
    end
  end

  assign rd_readable = rd_q[hit_way];

endmodule

// ==== logic/cache_rw_ctrl.sv ====
`timescale 1ns/100ps

module cache_rw_ctrl import cache_pkg::*; (
  input  logic     clk,
  input  logic     rest,
  input  cpu_req_t cpu_req,
  input  logic     refill_done,
  input  word_t    refill_rdata,
  input  lookup_t  lookup,
  input  word_t    rd_word,
  input  be_t      rd_readable,
  output logic     wait_request,
  output word_t    read_data,
  output logic     read_data_valid,
  output rw_cmd_e  refill_cmd,
  output cpu_req_t refill_info,
  output lookup_t  refill_lookup,
  output logic     rd_en,
  output addr_t    rd_addr,
  output addr_t    cmp_addr,
  output logic     hit_wr_en,
  output be_t      hit_wr_be,
  output word_t    hit_wr_data,
  output be_t      hit_readable
);

  rw_state_e state;
  cpu_req_t  stage;
  cpu_req_t  wbuf;
  logic      accept;
  logic      fwd_hit;
  word_t     fwd_word;
  be_t       fwd_readable;
  logic      is_io;
  logic      rd_fault;
  logic      wr_fault;
  logic      fault;

  // Write buffer covers the store write still in flight
  assign fwd_hit = wbuf.write && (wbuf.addr[31:2] == stage.addr[31:2]);

  always_comb begin
    fwd_word = rd_word;
    for (int b = 0; b < 4; b++) begin
      if (fwd_hit && wbuf.be[b]) begin
        fwd_word[8*b +: 8] = wbuf.wdata[8*b +: 8];
      end
    end
  end

  assign fwd_readable = fwd_hit ? (rd_readable | wbuf.be) : rd_readable;

  // Fault decision for the request under evaluation
  assign is_io    = stage.addr[31:28] == io_region;
  assign rd_fault = stage.read &&
                    (is_io || !lookup.hit || ((fwd_readable & stage.be) != stage.be));
  assign wr_fault = stage.write && (is_io || !lookup.hit);
  assign fault    = (state == st_idle) && (rd_fault || wr_fault);

  // Stalled until the agent signals done
  assign wait_request = (state == st_idle) ? fault : !refill_done;
  assign accept       = !wait_request;

  assign rd_en    = accept;
  assign rd_addr  = cpu_req.addr;
  assign cmp_addr = stage.addr;

  assign read_data       = (state == st_wait) ? refill_rdata : fwd_word;
  assign read_data_valid = (state == st_idle) ? (stage.read && !fault)
                                              : (stage.read && refill_done);

  // Write hit path into the data and readable stores
  assign hit_wr_en    = (state == st_idle) && stage.write && !fault;
  assign hit_wr_be    = stage.be;
  assign hit_wr_data  = stage.wdata;
  assign hit_readable = fwd_readable | stage.be;

  assign refill_info = stage;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      stage      <= '0;
      wbuf       <= '0;
      state      <= st_idle;
      refill_cmd <= cmd_nop;
    end else begin
      if (accept) begin
        stage <= cpu_req;
      end
      if (hit_wr_en) begin
        wbuf <= stage;
      end else if ((state == st_wait) && refill_done) begin
        // Refill may have rewritten the buffered word
        wbuf <= '0;
      end
      case (state)
        st_idle: begin
          if (fault) begin
            state      <= st_wait;
            refill_cmd <= is_io ? cmd_io : cmd_refill;
          end
        end
        st_wait: begin
          if (refill_done) begin
            state      <= st_idle;
            refill_cmd <= cmd_nop;
          end
        end
        default: begin
          state      <= st_idle;
          refill_cmd <= cmd_nop;
        end
      endcase
    end
  end

  // Lookup frozen while the agent works on the stalled request
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      refill_lookup <= lookup;
    end
  end

endmodule

// ==== logic/cache_rw.sv ====
`timescale 1ns/100ps

module cache_rw import cache_pkg::*; (
  input  logic       clk,
  input  logic       rest,
  input  cpu_req_t   cpu_req,
  input  refill_wr_t refill_wr,
  input  logic       refill_done,
  input  word_t      refill_rdata,
  output logic       wait_request,
  output word_t      read_data,
  output logic       read_data_valid,
  output rw_cmd_e    refill_cmd,
  output cpu_req_t   refill_info,
  output lookup_t    refill_lookup
);

  lookup_t lookup;
  word_t   rd_word;
  be_t     rd_readable;
  logic    rd_en;
  addr_t   rd_addr;
  addr_t   cmp_addr;
  logic    hit_wr_en;
  be_t     hit_wr_be;
  word_t   hit_wr_data;
  be_t     hit_readable;

  cache_rw_ctrl u_ctrl (
    .clk             (clk),
    .rest            (rest),
    .cpu_req         (cpu_req),
    .refill_done     (refill_done),
    .refill_rdata    (refill_rdata),
    .lookup          (lookup),
    .rd_word         (rd_word),
    .rd_readable     (rd_readable),
    .wait_request    (wait_request),
    .read_data       (read_data),
    .read_data_valid (read_data_valid),
    .refill_cmd      (refill_cmd),
    .refill_info     (refill_info),
    .refill_lookup   (refill_lookup),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .cmp_addr        (cmp_addr),
    .hit_wr_en       (hit_wr_en),
    .hit_wr_be       (hit_wr_be),
    .hit_wr_data     (hit_wr_data),
    .hit_readable    (hit_readable)
  );

  cache_tag_store u_tags (
    .clk       (clk),
    .rest      (rest),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .cmp_addr  (cmp_addr),
    .refill_wr (refill_wr),
    .lookup    (lookup)
  );

  // Hit writes use the stage address, which is also the compare address
  cache_data_store u_data (
    .clk         (clk),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .hit_way     (lookup.hit_way),
    .hit_wr_en   (hit_wr_en),
    .wr_addr     (cmp_addr),
    .hit_wr_be   (hit_wr_be),
    .hit_wr_data (hit_wr_data),
    .refill_wr   (refill_wr),
    .rd_word     (rd_word)
  );

  cache_byte_valid u_bytes (
    .clk          (clk),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .hit_way      (lookup.hit_way),
    .hit_wr_en    (hit_wr_en),
    .wr_addr      (cmp_addr),
    .hit_readable (hit_readable),
    .refill_wr    (refill_wr),
    .rd_readable  (rd_readable)
  );

endmodule

// ==== tb/cache_rw_sva.sv ====
`timescale 1ns/100ps

module cache_rw_sva import cache_pkg::*; (
  input logic    clk,
  input logic    rest,
  input logic    wait_request,
  input rw_cmd_e refill_cmd,
  input logic    refill_done
);

  // Command is a level held until the agent finishes
  cmd_held: assert property (@(posedge clk) disable iff (!rest)
    (refill_cmd != cmd_nop && !refill_done) |=> refill_cmd == $past(refill_cmd))
    else $error("refill_cmd changed before refill_done");

  cmd_idle_after_reset: assert property (@(posedge clk)
    $rose(rest) |-> refill_cmd == cmd_nop)
    else $error("refill_cmd was not nop in the first cycle after reset");

  // Processor stays stalled for the whole fault
  stall_while_busy: assert property (@(posedge clk) disable iff (!rest)
    (refill_cmd != cmd_nop && !refill_done) |-> wait_request)
    else $error("wait_request low while a refill command is pending");

  done_only_when_busy: assert property (@(posedge clk) disable iff (!rest)
    refill_done |-> refill_cmd != cmd_nop)
    else $error("refill_done pulsed without a refill command");

endmodule

bind cache_rw cache_rw_sva u_sva (
  .clk          (clk),
  .rest         (rest),
  .wait_request (wait_request),
  .refill_cmd   (refill_cmd),
  .refill_done  (refill_done)
);

// ==== tb/tb_cache_rw.sv ====
`timescale 1ns/100ps

module tb_cache_rw import cache_pkg::*; ();

  logic       clk;
  logic       rest;
  cpu_req_t   cpu_req;
  refill_wr_t refill_wr;
  logic       refill_done;
  word_t      refill_rdata;
  logic       wait_request;
  word_t      read_data;
  logic       read_data_valid;
  rw_cmd_e    refill_cmd;
  cpu_req_t   refill_info;
  lookup_t    refill_lookup;

  // Architectural memory, IO space and the cache state as the agent built it
  word_t       mem_model [addr_t];
  word_t       io_model [addr_t];
  tag_t        tag_mirror [num_ways][num_sets];
  logic        valid_mirror [num_ways][num_sets];
  be_t         readable_mirror [num_ways][num_sets][16];
  logic [31:0] rng;
  logic        last_write;
  addr_t       last_addr;
  int          errors;
  int          n_miss;
  int          n_partial;
  int          n_io;
  int          n_hit;
  cpu_req_t    cur;
  cpu_req_t    ev;

  cache_rw u_dut (
    .clk             (clk),
    .rest            (rest),
    .cpu_req         (cpu_req),
    .refill_wr       (refill_wr),
    .refill_done     (refill_done),
    .refill_rdata    (refill_rdata),
    .wait_request    (wait_request),
    .read_data       (read_data),
    .read_data_valid (read_data_valid),
    .refill_cmd      (refill_cmd),
    .refill_info     (refill_info),
    .refill_lookup   (refill_lookup)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Words never written read back a pattern of their address
  function automatic word_t stored_word(input addr_t a);
    addr_t key;
    key = {a[31:2], 2'b00};
    if (key[31:28] == io_region) begin
      return io_model.exists(key) ? io_model[key] : ~(key * 32'h9e37_79b1);
    end
    return mem_model.exists(key) ? mem_model[key] : (key * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
  endfunction

  function automatic void store_word(input addr_t a, input word_t w);
    addr_t key;
    key = {a[31:2], 2'b00};
    if (key[31:28] == io_region) begin
      io_model[key] = w;
    end else begin
      mem_model[key] = w;
    end
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t upd, input be_t be);
    word_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = upd[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic lookup_t predict_lookup(input addr_t a);
    lookup_t lk;
    index_t  idx;
    lk  = '0;
    idx = a[10:6];
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (valid_mirror[w][idx] && tag_mirror[w][idx] == a[31:11]) begin
        lk.hit     = 1'b1;
        lk.hit_way = way_t'(w);
      end
      if (!valid_mirror[w][idx]) begin
        lk.has_free = 1'b1;
        lk.free_way = way_t'(w);
      end
    end
    return lk;
  endfunction

  // Small pool of lines over four sets, so ways get evicted often
  function automatic cpu_req_t make_request();
    cpu_req_t    r;
    logic [31:0] x;
    logic [31:0] y;
    r = '0;
    x = draw();
    y = draw();
    if (last_write && x[0]) begin
      r.addr = last_addr;
      r.read = 1'b1;
      r.be   = 4'hF;
    end else if (x[3:1] != 3'd0) begin
      if (x[6:4] == 3'd0) begin
        r.addr = {4'hF, 22'h0, y[5:2], 2'b00};
      end else begin
        r.addr = {18'h00008, y[2:0], 3'b000, y[4:3], 2'b00, y[6:5], 2'b00};
      end
      r.wdata = draw();
      r.be    = (y[10:7] == 4'h0) ? 4'hF : y[10:7];
      r.read  = y[11];
      r.write = !y[11];
    end
    last_write = r.write;
    last_addr  = r.addr;
    return r;
  endfunction

  task automatic stop_run(input string why);
    errors++;
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cmd(input string name, input rw_cmd_e got, input rw_cmd_e exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_lookup(input string name, input lookup_t got, input lookup_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_req(input string name, input cpu_req_t got, input cpu_req_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic refill_write(input logic tag_we, input way_t way, input addr_t a,
                              input word_t wdata, input be_t be);
    refill_wr         = '0;
    refill_wr.tag_we  = tag_we;
    refill_wr.data_we = !tag_we;
    refill_wr.way     = way;
    refill_wr.addr    = a;
    refill_wr.tag     = a[31:11];
    refill_wr.wdata   = wdata;
    refill_wr.be      = be;
    @(posedge clk);
    #0.5;
    refill_wr = '0;
  endtask

  task automatic wait_for_cmd();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #0.5;
      cycles++;
    end while (refill_cmd == cmd_nop && cycles < 8);
    if (refill_cmd == cmd_nop) begin
      stop_run("refill command did not appear within 8 cycles of a fault");
    end
  endtask

  // Refill agent, entered in the cycle where the fault is seen
  task automatic serve_fault(input cpu_req_t r, input lookup_t lk);
    logic        io;
    way_t        way;
    index_t      idx;
    logic [31:0] x;
    addr_t       a;
    be_t         be;
    word_t       rdata;
    int          delay;
    io  = r.addr[31:28] == io_region;
    idx = r.addr[10:6];
    wait_for_cmd();
    check_cmd("refill_cmd", refill_cmd, io ? cmd_io : cmd_refill);
    check_lookup("refill_lookup", refill_lookup, lk);
    check_req("refill_info", refill_info, r);
    if (r.write) begin
      store_word(r.addr, merge_bytes(stored_word(r.addr), r.wdata, r.be));
    end
    if (io) begin
      n_io++;
    end else if (lk.hit) begin
      n_partial++;
      refill_write(1'b0, lk.hit_way, r.addr, stored_word(r.addr), 4'hF);
      readable_mirror[lk.hit_way][idx][r.addr[5:2]] = 4'hF;
    end else begin
      n_miss++;
      x   = draw();
      way = lk.has_free ? lk.free_way : x[1:0];
      refill_write(1'b1, way, r.addr, '0, '0);
      for (int k = 0; k < 16; k++) begin
        a  = {r.addr[31:6], k[3:0], 2'b00};
        be = (a[5:2] == r.addr[5:2]) ? 4'hF : 4'h0;
        refill_write(1'b0, way, a, stored_word(a), be);
        readable_mirror[way][idx][k] = be;
      end
      tag_mirror[way][idx]   = r.addr[31:11];
      valid_mirror[way][idx] = 1'b1;
    end
    rdata = stored_word(r.addr);
    x     = draw();
    delay = int'(x[1:0]);
    repeat (delay) begin
      @(posedge clk);
      #0.5;
    end
    refill_done  = 1'b1;
    refill_rdata = rdata;
    @(negedge clk);
    check_bit("wait_request", wait_request, 1'b0);
    check_bit("read_data_valid", read_data_valid, r.read);
    if (r.read) begin
      check_word("read_data", read_data, rdata);
    end
  endtask

  // Evaluation cycle of the request accepted at the last edge
  task automatic evaluate(input cpu_req_t r);
    lookup_t lk;
    logic    fault;
    be_t     have;
    word_t   mask;
    lk    = predict_lookup(r.addr);
    have  = readable_mirror[lk.hit_way][r.addr[10:6]][r.addr[5:2]];
    fault = (r.addr[31:28] == io_region) || !lk.hit || (r.read && ((have & r.be) != r.be));
    mask  = {{8{r.be[3]}}, {8{r.be[2]}}, {8{r.be[1]}}, {8{r.be[0]}}};
    check_cmd("refill_cmd", refill_cmd, cmd_nop);
    if (!(r.read || r.write)) begin
      check_bit("wait_request", wait_request, 1'b0);
      check_bit("read_data_valid", read_data_valid, 1'b0);
    end else if (fault) begin
      check_bit("wait_request", wait_request, 1'b1);
      check_bit("read_data_valid", read_data_valid, 1'b0);
      serve_fault(r, lk);
    end else if (r.read) begin
      n_hit++;
      check_bit("wait_request", wait_request, 1'b0);
      check_bit("read_data_valid", read_data_valid, 1'b1);
      check_word("read_data", read_data & mask, stored_word(r.addr) & mask);
    end else begin
      check_bit("wait_request", wait_request, 1'b0);
      check_bit("read_data_valid", read_data_valid, 1'b0);
      store_word(r.addr, merge_bytes(stored_word(r.addr), r.wdata, r.be));
      readable_mirror[lk.hit_way][r.addr[10:6]][r.addr[5:2]] = have | r.be;
    end
  endtask

  initial begin
    rng          = 32'h99ab_2178;
    errors       = 0;
    n_miss       = 0;
    n_partial    = 0;
    n_io         = 0;
    n_hit        = 0;
    last_write   = 1'b0;
    last_addr    = '0;
    rest         = 1'b0;
    cpu_req      = '0;
    refill_wr    = '0;
    refill_done  = 1'b0;
    refill_rdata = '0;
    cur          = '0;
    ev           = '0;
    for (int w = 0; w < num_ways; w++) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_mirror[w][s] = 1'b0;
      end
    end
    repeat (8) @(posedge clk);
    #0.5;
    rest = 1'b1;
    @(negedge clk);
    check_bit("wait_request", wait_request, 1'b0);
    check_bit("read_data_valid", read_data_valid, 1'b0);
    check_cmd("refill_cmd", refill_cmd, cmd_nop);
    // Every iteration ends in a cycle where the held request is accepted
    for (int n = 0; n < 3000; n++) begin
      @(posedge clk);
      #0.5;
      refill_done  = 1'b0;
      refill_rdata = '0;
      ev           = cur;
      cur          = make_request();
      cpu_req      = cur;
      @(negedge clk);
      evaluate(ev);
    end
    if (n_miss == 0 || n_partial == 0 || n_io == 0 || n_hit == 0) begin
      stop_run("random stimulus never reached one of the miss, partial, IO or hit cases");
    end
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== cache_rw.f ====
logic/cache_pkg.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_byte_valid.sv
logic/cache_rw_ctrl.sv
logic/cache_rw.sv
tb/cache_rw_sva.sv
tb/tb_cache_rw.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cache_rw -f cache_rw.f -o tb_cache_rw
./obj_dir/tb_cache_rw | tee /dev/stderr | grep "TB PASSED" > /dev/null
